/* src/vlane_pkg.sv */
`default_nettype none

package vlane_pkg;

   ////////////////////////////////////////////////////////////
   // Lane geometry
   ////////////////////////////////////////////////////////////

   localparam int VLANE_NUM      = 8;   // Lanes, also ALU slots
   localparam int BYTES_PER_LANE = 4;
   localparam int BYTE_W         = 8;
   localparam int WORD_W         = BYTES_PER_LANE * BYTE_W;
   localparam int HALF_W         = WORD_W / 2;
   localparam int IMM_WIDTH      = 5;

   typedef logic [WORD_W-1:0] lane_word_t;

   // Indexed by lane or by ALU slot
   typedef lane_word_t [VLANE_NUM-1:0] lane_vec_t;

   ////////////////////////////////////////////////////////////
   // Control codes
   ////////////////////////////////////////////////////////////

   // Element width, code 3 illegal
   typedef logic [1:0] sew_t;
   localparam sew_t SEW8  = 2'd0;
   localparam sew_t SEW16 = 2'd1;
   localparam sew_t SEW32 = 2'd2;

   // Codes 5..7 illegal
   typedef logic [2:0] alu_op_t;
   localparam alu_op_t OP_ADD = 3'd0;
   localparam alu_op_t OP_SUB = 3'd1;   // op1 - op2
   localparam alu_op_t OP_AND = 3'd2;
   localparam alu_op_t OP_OR  = 3'd3;
   localparam alu_op_t OP_XOR = 3'd4;

   // Operand 2 source, code 3 illegal
   typedef logic [1:0] op2_sel_t;
   localparam op2_sel_t OP2_VEC    = 2'd0;
   localparam op2_sel_t OP2_SCALAR = 2'd1;
   localparam op2_sel_t OP2_IMM    = 2'd2;

endpackage

`default_nettype wire

/* src/vlane_operand_gather.sv */
`timescale 1ns/100ps
`default_nettype none

module vlane_operand_gather
(
   input  wire                             clk_i,
   input  wire                             rst_i,
   input  wire                             in_valid_i,
   input  wire vlane_pkg::sew_t            sew_i,
   input  wire vlane_pkg::alu_op_t         alu_op_i,
   input  wire vlane_pkg::op2_sel_t        op2_sel_i,
   input  wire vlane_pkg::lane_vec_t       vs1_i,
   input  wire vlane_pkg::lane_vec_t       vs2_i,
   input  wire vlane_pkg::lane_word_t      scalar_i,
   input  wire [vlane_pkg::IMM_WIDTH-1:0]  imm_i,
   output logic                            valid_o,
   output vlane_pkg::sew_t                 sew_o,
   output vlane_pkg::alu_op_t              alu_op_o,
   output vlane_pkg::lane_vec_t            op_a_o,
   output vlane_pkg::lane_vec_t            op_b_o
);

   // Byte b of lanes 2j and 2j+1 into slot b*4+j
   function automatic vlane_pkg::lane_vec_t gather16(input vlane_pkg::lane_vec_t v);
      vlane_pkg::lane_vec_t g;
      g = '0;
      for (int b = 0; b < 2; b++)
      begin
         for (int j = 0; j < vlane_pkg::VLANE_NUM/2; j++)
         begin
            g[b*(vlane_pkg::VLANE_NUM/2)+j][vlane_pkg::HALF_W-1:0] =
               {v[2*j+1][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W],
                v[2*j][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W]};
         end
      end
      return g;
   endfunction

   // Byte b of lanes 4j..4j+3 into slot b*2+j
   function automatic vlane_pkg::lane_vec_t gather32(input vlane_pkg::lane_vec_t v);
      vlane_pkg::lane_vec_t g;
      for (int b = 0; b < vlane_pkg::BYTES_PER_LANE; b++)
      begin
         for (int j = 0; j < vlane_pkg::VLANE_NUM/4; j++)
         begin
            for (int k = 0; k < 4; k++)
               g[b*(vlane_pkg::VLANE_NUM/4)+j][k*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] =
                  v[4*j+k][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W];
         end
      end
      return g;
   endfunction

   // Scalar or immediate shaped for one slot
   function automatic vlane_pkg::lane_word_t fit_word(input vlane_pkg::lane_word_t w,
                                                     input vlane_pkg::sew_t sew);
      case (sew)
         vlane_pkg::SEW8:  fit_word = {vlane_pkg::BYTES_PER_LANE{w[vlane_pkg::BYTE_W-1:0]}};
         vlane_pkg::SEW16: fit_word = {{vlane_pkg::HALF_W{1'b0}}, w[vlane_pkg::HALF_W-1:0]};
         default:          fit_word = w;
      endcase
   endfunction

   vlane_pkg::lane_vec_t  a_16, a_32, b_16, b_32;
   vlane_pkg::lane_vec_t  op_a, op_b, vs2_gth;
   vlane_pkg::lane_word_t imm_ext;

   assign a_16    = gather16(vs1_i);
   assign a_32    = gather32(vs1_i);
   assign b_16    = gather16(vs2_i);
   assign b_32    = gather32(vs2_i);
   assign imm_ext = {{(vlane_pkg::WORD_W-vlane_pkg::IMM_WIDTH){imm_i[vlane_pkg::IMM_WIDTH-1]}},
                     imm_i};

   always_comb
   begin
      case (sew_i)
         vlane_pkg::SEW8:
         begin
            op_a    = vs1_i;   // Lane local
            vs2_gth = vs2_i;
         end
         vlane_pkg::SEW16:
         begin
            op_a    = a_16;
            vs2_gth = b_16;
         end
         vlane_pkg::SEW32:
         begin
            op_a    = a_32;
            vs2_gth = b_32;
         end
         default:
         begin
            op_a    = '0;
            vs2_gth = '0;
         end
      endcase

      case (op2_sel_i)
         vlane_pkg::OP2_SCALAR: op_b = {vlane_pkg::VLANE_NUM{fit_word(scalar_i, sew_i)}};
         vlane_pkg::OP2_IMM:    op_b = {vlane_pkg::VLANE_NUM{fit_word(imm_ext, sew_i)}};
         default:               op_b = vs2_gth;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= in_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (in_valid_i)
      begin
         sew_o    <= sew_i;
         alu_op_o <= alu_op_i;
         op_a_o   <= op_a;
         op_b_o   <= op_b;
      end
   end

   a_legal_codes: assert property (@(posedge clk_i) disable iff (!rst_i)
      in_valid_i |-> (sew_i != 2'd3) && (op2_sel_i != 2'd3));

endmodule

`default_nettype wire

/* src/vlane_alu_array.sv */
`timescale 1ns/100ps
`default_nettype none

module vlane_alu_array
(
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        valid_i,
   input  wire vlane_pkg::sew_t       sew_i,
   input  wire vlane_pkg::alu_op_t    alu_op_i,
   input  wire vlane_pkg::lane_vec_t  op_a_i,
   input  wire vlane_pkg::lane_vec_t  op_b_i,
   output logic                       valid_o,
   output vlane_pkg::sew_t            sew_o,
   output vlane_pkg::lane_vec_t       res_o
);

   // Full word op, narrower widths take the low bits
   function automatic vlane_pkg::lane_word_t apply_op(input vlane_pkg::lane_word_t a,
                                                     input vlane_pkg::lane_word_t b,
                                                     input vlane_pkg::alu_op_t op);
      case (op)
         vlane_pkg::OP_ADD: apply_op = a + b;
         vlane_pkg::OP_SUB: apply_op = a - b;
         vlane_pkg::OP_AND: apply_op = a & b;
         vlane_pkg::OP_OR:  apply_op = a | b;
         vlane_pkg::OP_XOR: apply_op = a ^ b;
         default:           apply_op = '0;
      endcase
   endfunction

   vlane_pkg::lane_vec_t alu_res;

   ////////////////////////////////////////////////////////////
   // Slots
   ////////////////////////////////////////////////////////////

   for (genvar s = 0; s < vlane_pkg::VLANE_NUM; s++)
   begin : g_slot
      vlane_pkg::lane_word_t slot_res;

      always_comb
      begin
         vlane_pkg::lane_word_t part;
         slot_res = '0;
         case (sew_i)
            vlane_pkg::SEW8:
            begin
               // Carries stop at each byte
               for (int k = 0; k < vlane_pkg::BYTES_PER_LANE; k++)
               begin
                  part = apply_op(
                     vlane_pkg::lane_word_t'(op_a_i[s][k*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W]),
                     vlane_pkg::lane_word_t'(op_b_i[s][k*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W]),
                     alu_op_i);
                  slot_res[k*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] = part[vlane_pkg::BYTE_W-1:0];
               end
            end
            vlane_pkg::SEW16:
            begin
               part = apply_op(vlane_pkg::lane_word_t'(op_a_i[s][vlane_pkg::HALF_W-1:0]),
                               vlane_pkg::lane_word_t'(op_b_i[s][vlane_pkg::HALF_W-1:0]),
                               alu_op_i);
               slot_res[vlane_pkg::HALF_W-1:0] = part[vlane_pkg::HALF_W-1:0];   // Upper half zero
            end
            vlane_pkg::SEW32:
            begin
               part     = apply_op(op_a_i[s], op_b_i[s], alu_op_i);
               slot_res = part;
            end
            default:
               part = '0;
         endcase
      end

      assign alu_res[s] = slot_res;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         sew_o <= sew_i;
         res_o <= alu_res;
      end
   end

   a_legal_op: assert property (@(posedge clk_i) disable iff (!rst_i)
      valid_i |-> alu_op_i <= vlane_pkg::OP_XOR);

endmodule

`default_nettype wire

/* src/vlane_result_scatter.sv */
`timescale 1ns/100ps
`default_nettype none

module vlane_result_scatter
(
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        valid_i,
   input  wire vlane_pkg::sew_t       sew_i,
   input  wire vlane_pkg::lane_vec_t  res_i,
   output logic                       valid_o,
   output vlane_pkg::lane_vec_t       result_o
);

   // Flat byte view, slot s byte k at s*4+k
   logic [vlane_pkg::VLANE_NUM*vlane_pkg::BYTES_PER_LANE-1:0][vlane_pkg::BYTE_W-1:0] res_bytes;
   vlane_pkg::lane_vec_t lane_res;

   assign res_bytes = res_i;

   ////////////////////////////////////////////////////////////
   // Inverse of the operand gather
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      lane_res = '0;
      for (int l = 0; l < vlane_pkg::VLANE_NUM; l++)
      begin
         for (int b = 0; b < vlane_pkg::BYTES_PER_LANE; b++)
         begin
            case (sew_i)
               vlane_pkg::SEW8:
                  lane_res[l][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] =
                     res_bytes[l*vlane_pkg::BYTES_PER_LANE + b];
               vlane_pkg::SEW16:
               begin
                  if (b < 2)   // Bytes 2 and 3 stay zero
                     lane_res[l][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] =
                        res_bytes[(b*(vlane_pkg::VLANE_NUM/2) + l/2)*vlane_pkg::BYTES_PER_LANE
                                  + l%2];
               end
               vlane_pkg::SEW32:
                  lane_res[l][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] =
                     res_bytes[(b*(vlane_pkg::VLANE_NUM/4) + l/4)*vlane_pkg::BYTES_PER_LANE
                               + l%4];
               default:
                  lane_res[l][b*vlane_pkg::BYTE_W +: vlane_pkg::BYTE_W] = '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
         result_o <= lane_res;
   end

   // A valid result never takes the zero fill for width code 3
   a_legal_sew: assert property (@(posedge clk_i) disable iff (!rst_i)
      valid_i |-> sew_i != 2'd3);

endmodule

`default_nettype wire

/* src/vlane_datapath_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vlane_datapath_top
(
   input  wire                             clk_i,
   input  wire                             rst_i,
   input  wire                             in_valid_i,
   input  wire vlane_pkg::sew_t            sew_i,
   input  wire vlane_pkg::alu_op_t         alu_op_i,
   input  wire vlane_pkg::op2_sel_t        op2_sel_i,
   input  wire vlane_pkg::lane_vec_t       vs1_i,
   input  wire vlane_pkg::lane_vec_t       vs2_i,
   input  wire vlane_pkg::lane_word_t      scalar_i,
   input  wire [vlane_pkg::IMM_WIDTH-1:0]  imm_i,
   output logic                            out_valid_o,
   output vlane_pkg::lane_vec_t            result_o
);

   // Gather to ALU
   logic                 gth_valid;
   vlane_pkg::sew_t      gth_sew;
   vlane_pkg::alu_op_t   gth_op;
   vlane_pkg::lane_vec_t gth_a;
   vlane_pkg::lane_vec_t gth_b;

   // ALU to scatter
   logic                 alu_valid;
   vlane_pkg::sew_t      alu_sew;
   vlane_pkg::lane_vec_t alu_res;

   vlane_operand_gather u_gather
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_valid_i (in_valid_i),
      .sew_i      (sew_i),
      .alu_op_i   (alu_op_i),
      .op2_sel_i  (op2_sel_i),
      .vs1_i      (vs1_i),
      .vs2_i      (vs2_i),
      .scalar_i   (scalar_i),
      .imm_i      (imm_i),
      .valid_o    (gth_valid),
      .sew_o      (gth_sew),
      .alu_op_o   (gth_op),
      .op_a_o     (gth_a),
      .op_b_o     (gth_b)
   );

   vlane_alu_array u_alu
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .valid_i  (gth_valid),
      .sew_i    (gth_sew),
      .alu_op_i (gth_op),
      .op_a_i   (gth_a),
      .op_b_i   (gth_b),
      .valid_o  (alu_valid),
      .sew_o    (alu_sew),
      .res_o    (alu_res)
   );

   vlane_result_scatter u_scatter
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .valid_i  (alu_valid),
      .sew_i    (alu_sew),
      .res_i    (alu_res),
      .valid_o  (out_valid_o),
      .result_o (result_o)
   );

endmodule

`default_nettype wire

/* testbench/tb_vlane_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vlane_datapath;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_GROUPS = 36;   // 1 + 5 + 4 + 6 + 20
   localparam int MARGIN_NS  = 2000;
   localparam int TIMEOUT_NS = (NUM_GROUPS + 3 + 16) * CLK_PERIOD + MARGIN_NS;

   logic                               clk = 1'b0;
   logic                               rst;
   logic                               in_valid;
   vlane_pkg::sew_t                    sew_in;
   vlane_pkg::alu_op_t                 op_in;
   vlane_pkg::op2_sel_t                sel_in;
   vlane_pkg::lane_vec_t               vs1;
   vlane_pkg::lane_vec_t               vs2;
   vlane_pkg::lane_word_t              scalar;
   logic [vlane_pkg::IMM_WIDTH-1:0]    imm;
   wire                                out_valid;
   vlane_pkg::lane_vec_t               result;

   vlane_pkg::lane_vec_t exp_q[$];
   vlane_pkg::lane_vec_t expv;
   integer               seed;
   int                   errors   = 0;
   int                   checks   = 0;
   int                   issued   = 0;
   int                   run_len  = 0;
   int                   last_run = 0;

   vlane_datapath_top u_dut
   (
      .clk_i       (clk),
      .rst_i       (rst),
      .in_valid_i  (in_valid),
      .sew_i       (sew_in),
      .alu_op_i    (op_in),
      .op2_sel_i   (sel_in),
      .vs1_i       (vs1),
      .vs2_i       (vs2),
      .scalar_i    (scalar),
      .imm_i       (imm),
      .out_valid_o (out_valid),
      .result_o    (result)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Reference model, element by element from the layout rule
   ////////////////////////////////////////////////////////////

   function automatic vlane_pkg::lane_vec_t model_result(
      input vlane_pkg::lane_vec_t a, input vlane_pkg::lane_vec_t b,
      input vlane_pkg::lane_word_t sc, input logic [vlane_pkg::IMM_WIDTH-1:0] im,
      input vlane_pkg::sew_t sew, input vlane_pkg::alu_op_t op,
      input vlane_pkg::op2_sel_t sel);
      vlane_pkg::lane_vec_t r;
      int                   w;
      int                   rows;
      logic [31:0]          ea, eb, er, mask;
      r    = '0;
      w    = (sew == vlane_pkg::SEW8) ? 1 : (sew == vlane_pkg::SEW16) ? 2 : 4;
      rows = (sew == vlane_pkg::SEW16) ? 2 : 4;   // SEW16 uses lane bytes 0 and 1
      mask = (w == 4) ? 32'hffff_ffff : (32'h1 << (8*w)) - 1;
      for (int bt = 0; bt < rows; bt++)
      begin
         for (int j = 0; j < 8/w; j++)
         begin
            ea = '0;
            eb = '0;
            for (int k = 0; k < w; k++)
            begin
               ea[8*k +: 8] = a[w*j+k][8*bt +: 8];
               eb[8*k +: 8] = b[w*j+k][8*bt +: 8];
            end
            if (sel == vlane_pkg::OP2_SCALAR)
               eb = sc;
            else if (sel == vlane_pkg::OP2_IMM)
               eb = {{(32-vlane_pkg::IMM_WIDTH){im[vlane_pkg::IMM_WIDTH-1]}}, im};
            case (op)
               vlane_pkg::OP_ADD: er = ea + eb;
               vlane_pkg::OP_SUB: er = ea - eb;
               vlane_pkg::OP_AND: er = ea & eb;
               vlane_pkg::OP_OR:  er = ea | eb;
               default:           er = ea ^ eb;
            endcase
            er = er & mask;   // Wraps at element width
            for (int k = 0; k < w; k++)
               r[w*j+k][8*bt +: 8] = er[8*k +: 8];
         end
      end
      return r;
   endfunction

   task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                              input string msg);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic rand_vec(output vlane_pkg::lane_vec_t v);
      for (int l = 0; l < vlane_pkg::VLANE_NUM; l++)
         v[l] = $random(seed);
   endtask

   task automatic send_group(input vlane_pkg::sew_t sew, input vlane_pkg::alu_op_t op,
                             input vlane_pkg::op2_sel_t sel, input vlane_pkg::lane_vec_t a,
                             input vlane_pkg::lane_vec_t b, input vlane_pkg::lane_word_t sc,
                             input logic [vlane_pkg::IMM_WIDTH-1:0] im);
      @(posedge clk);
      in_valid <= 1'b1;
      sew_in   <= sew;
      op_in    <= op;
      sel_in   <= sel;
      vs1      <= a;
      vs2      <= b;
      scalar   <= sc;
      imm      <= im;
      exp_q.push_back(model_result(a, b, sc, im, sew, op, sel));
      issued++;
   endtask

   task automatic end_burst;
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic wait_results;
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 40)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("results missing at %0t ns, %0d groups never came out", $time, exp_q.size());
         exp_q.delete();
      end
      repeat (2) @(negedge clk);   // Let the run length settle
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk)
   begin
      if (rst && out_valid)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("output appeared at %0t ns with no group pending", $time);
         end
         else
         begin
            expv = exp_q.pop_front();
            check_value(result, expv, "result lane vector");
         end
         run_len++;
      end
      else
      begin
         if (run_len != 0)
            last_run = run_len;
         run_len = 0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic reset_and_latency;
      vlane_pkg::lane_vec_t a, b;
      int                   cycles;
      logic                 seen;
      @(negedge clk);
      check_value(out_valid, 1'b0, "out_valid after reset");
      rand_vec(a);
      rand_vec(b);
      send_group(vlane_pkg::SEW32, vlane_pkg::OP_ADD, vlane_pkg::OP2_VEC, a, b, '0, '0);
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 8)
      begin
         @(posedge clk);
         in_valid <= 1'b0;
         cycles++;
         @(negedge clk);
         seen = out_valid;
      end
      check_value(cycles, 3, "latency in cycles");
      wait_results;
      check_value(last_run, 1, "out_valid pulse length");
   endtask

   task automatic sew8_lane_ops;
      vlane_pkg::lane_vec_t a, b;
      for (int op = 0; op < 5; op++)
      begin
         rand_vec(a);
         rand_vec(b);
         a[0][7:0] = 8'hff;   // ff + 01 must not carry into byte 1
         b[0][7:0] = 8'h01;
         send_group(vlane_pkg::SEW8, vlane_pkg::alu_op_t'(op), vlane_pkg::OP2_VEC,
                    a, b, '0, '0);
      end
      end_burst;
      wait_results;
   endtask

   task automatic cross_lane_carry;
      vlane_pkg::lane_vec_t a, b;
      // 16-bit carry from lane 2j into lane 2j+1, junk in bytes 2 and 3
      for (int l = 0; l < 8; l++)
      begin
         a[l] = (l % 2 == 0) ? 32'ha5a5_ffff : 32'h5a5a_1212;
         b[l] = (l % 2 == 0) ? 32'hc3c3_0101 : 32'h0000_0000;
      end
      send_group(vlane_pkg::SEW16, vlane_pkg::OP_ADD, vlane_pkg::OP2_VEC, a, b, '0, '0);
      for (int l = 0; l < 8; l++)
         a[l] = (l % 2 == 0) ? 32'h7e7e_0000 : 32'h8181_1212;
      send_group(vlane_pkg::SEW16, vlane_pkg::OP_SUB, vlane_pkg::OP2_VEC, a, b, '0, '0);
      // 32-bit ripple through lanes 4j+1..4j+3
      for (int l = 0; l < 8; l++)
      begin
         a[l] = (l % 4 == 3) ? 32'h0101_0101 : 32'hffff_ffff;
         b[l] = (l % 4 == 0) ? 32'h0101_0101 : 32'h0000_0000;
      end
      send_group(vlane_pkg::SEW32, vlane_pkg::OP_ADD, vlane_pkg::OP2_VEC, a, b, '0, '0);
      for (int l = 0; l < 8; l++)
         a[l] = (l % 4 == 3) ? 32'h0505_0505 : 32'h0000_0000;
      send_group(vlane_pkg::SEW32, vlane_pkg::OP_SUB, vlane_pkg::OP2_VEC, a, b, '0, '0);
      end_burst;
      wait_results;
   endtask

   task automatic scalar_imm_sources;
      vlane_pkg::lane_vec_t a, b;
      for (int s = 0; s < 3; s++)
      begin
         rand_vec(a);
         rand_vec(b);   // Ignored by the DUT
         send_group(vlane_pkg::sew_t'(s), vlane_pkg::OP_ADD, vlane_pkg::OP2_SCALAR,
                    a, b, 32'h8765_43f9, '0);
         send_group(vlane_pkg::sew_t'(s), vlane_pkg::OP_ADD, vlane_pkg::OP2_IMM,
                    a, b, 32'h0, 5'b11101);   // -3
      end
      end_burst;
      wait_results;
   endtask

   task automatic back_to_back_stream;
      vlane_pkg::lane_vec_t  a, b;
      vlane_pkg::lane_word_t sc;
      logic [4:0]            im;
      for (int g = 0; g < 20; g++)
      begin
         rand_vec(a);
         rand_vec(b);
         sc = $random(seed);
         im = $random(seed);
         send_group(vlane_pkg::sew_t'($unsigned($random(seed)) % 3),
                    vlane_pkg::alu_op_t'($unsigned($random(seed)) % 5),
                    vlane_pkg::op2_sel_t'($unsigned($random(seed)) % 3), a, b, sc, im);
      end
      end_burst;
      wait_results;
      check_value(last_run, 20, "consecutive output cycles");
   endtask

   initial
   begin
      seed = 32'hccc6211e;
      rst      <= 1'b0;
      in_valid <= 1'b0;
      sew_in   <= vlane_pkg::SEW8;
      op_in    <= vlane_pkg::OP_ADD;
      sel_in   <= vlane_pkg::OP2_VEC;
      vs1      <= '0;
      vs2      <= '0;
      scalar   <= '0;
      imm      <= '0;
      repeat (16) @(posedge clk);
      rst <= 1'b1;

      reset_and_latency;
      sew8_lane_ops;
      cross_lane_carry;
      scalar_imm_sources;
      back_to_back_stream;

      $display("%0d errors in %0d checks over %0d groups", errors, checks, issued);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_NS);
      $display("run timed out after %0d ns before the tests finished", TIMEOUT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
src/vlane_pkg.sv
src/vlane_operand_gather.sv
src/vlane_alu_array.sv
src/vlane_result_scatter.sv
src/vlane_datapath_top.sv
testbench/tb_vlane_datapath.sv

/* Bender.yml */
package:
  name: vlane_datapath

sources:
  - src/vlane_pkg.sv
  - src/vlane_operand_gather.sv
  - src/vlane_alu_array.sv
  - src/vlane_result_scatter.sv
  - src/vlane_datapath_top.sv
  - target: test
    files:
      - testbench/tb_vlane_datapath.sv
